// File: hazard_stim.txt
# inValid instr reg1Data imm branchTaken  expReady expOutValid expFwd(exRs memRs exRt memRt)
# inValid 2 is a random idle gap, expOutValid 2 then follows the picked inValid
0 0000 0000 0000 0  1 0 0000  # Idle after reset, empty shadows
1 4264 0000 0000 0  1 1 0000  # r1 = r2,r3
1 45d0 0000 0000 0  1 1 0000  # r4 = r5,r6 independent
2 0800 0000 0000 0  1 2 0000  # Nop gap
2 0800 0000 0000 0  1 2 0000
1 4008 0000 0000 0  1 1 0000  # Writer r2 = r0,r0
1 420c 0000 0000 0  1 1 1000  # r3 = r2,r0 with r2 in ID
1 4058 0000 0000 0  1 1 0001  # r6 = r0,r2 with r2 in EX
1 421c 0000 0000 0  0 0 0000  # r7 = r2,r0 with r2 in MEM
1 421c 0000 0000 0  0 0 0000  # r2 in WB
1 421c 0000 0000 0  1 1 0000  # r2 gone
1 8820 0100 0020 0  1 1 0000  # Load r1 from 0x120
1 4108 0000 0000 0  0 0 0000  # Load use of r1
1 4108 0000 0000 0  1 1 0100  # Load now in EX
1 8380 0100 0020 0  0 0 0000  # Store to 0x120, load in MEM
1 8380 0100 0020 0  0 0 0000  # Load in WB
1 8380 0100 0020 0  1 1 0000  # Load gone
1 8380 0100 0024 0  1 1 0000  # Store to 0x124 passes the one to 0x120
1 3000 0000 0000 0  1 1 0000  # Jal writes r7
1 470c 0000 0000 0  0 0 1000  # Fetch bubble, r3 = r7,r0
1 470c 0000 0000 0  1 1 0100  # Link value in EX
1 88a0 0200 0000 0  1 1 0000  # Load r5 from 0x200
1 4518 0000 0000 1  1 1 0000  # Branch kills the load in ID
1 4504 0000 0000 0  1 1 0000  # Killed r5 in EX ignored
1 41c8 0000 0000 1  1 1 0001  # Branch drops the ID forward, keeps EX
1 8000 0200 0000 0  1 1 0000  # Address of the killed load is free
2 0800 0000 0000 0  1 2 0000
0 0800 0000 0000 0  1 0 0000

// File: verilog.f
+incdir+.
hazard_pkg.sv
instrDecode.sv
stageShadow.sv
hazardCtrl.sv
hazardUnit.sv
hazard_properties.sv
hazard_tb.sv

// File: run.sh
#!/bin/sh
# Build the model from verilog.f and run it, a $fatal gives a non-zero status
verilator --binary --timing --assert --top-module hazard_tb -f verilog.f -o hazardSim \
    && ./obj_dir/hazardSim \
    || { echo "Simulation build or run failed"; exit 1; }

// File: hazard_tb.sv
`timescale 1ns/1ps
`include "hazard_defines.svh"

module hazard_tb;

    // One line of hazard_stim.txt
    typedef struct packed {
        logic [1:0]         valid;    // 2 marks an idle gap picked at random
        logic [15:0]        instr;
        logic [`DATA_W-1:0] reg1Data;
        logic [`DATA_W-1:0] imm;
        logic               branch;
        logic               expReady;
        logic [1:0]         expOut;   // 2 means outValid follows the picked inValid
        logic [3:0]         expFwd;   // exRs memRs exRt memRt
    } vecT;

    logic               clk;
    logic               arstN;
    logic               inValid;
    logic               branchTaken;
    hazard_pkg::instrT  inInstr;
    logic [`DATA_W-1:0] inReg1Data;
    logic [`DATA_W-1:0] inImm;
    logic               inReady;
    logic               outValid;
    hazard_pkg::issueT  outIssue;

    vecT vecs[$];
    int  numVecs = -1; // Set once the file is loaded

    hazardUnit uut (
        .clk(clk), .arstN(arstN), .inValid(inValid), .branchTaken(branchTaken),
        .inInstr(inInstr), .inReg1Data(inReg1Data), .inImm(inImm),
        .inReady(inReady), .outValid(outValid), .outIssue(outIssue)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk; // 8 ns period

    task automatic checkValue(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("MISMATCH at time %0t: %s is %0h, expected %0h", $time, what, actual,
                     expected);
            $display("Something failed");
            $fatal(1, "Output check failed");
        end
    endtask

    // Comment and blank lines are skipped, everything else must hold eight fields
    task automatic loadVectors();
        int          fd;
        int          n;
        int          vld;
        int          br;
        int          rdy;
        int          outE;
        logic [15:0] ins;
        logic [15:0] r1;
        logic [15:0] im;
        logic [3:0]  fw;
        string       line;
        vecT         v;
        fd = $fopen("hazard_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file hazard_stim.txt");
            $display("Something failed");
            $fatal(1, "No stimulus");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                n = $sscanf(line, "%d %h %h %h %d %d %d %b", vld, ins, r1, im, br, rdy,
                            outE, fw);
                if (n != 8) begin
                    $display("Stimulus line could not be parsed: %s", line);
                    $display("Something failed");
                    $fatal(1, "Bad stimulus");
                end else begin
                    v.valid    = 2'(vld);
                    v.instr    = ins;
                    v.reg1Data = r1;
                    v.imm      = im;
                    v.branch   = 1'(br);
                    v.expReady = 1'(rdy);
                    v.expOut   = 2'(outE);
                    v.expFwd   = fw;
                    vecs.push_back(v);
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        vecT         v;
        logic [31:0] rnd;
        logic        pick;        // inValid actually driven
        logic        expOutValid;
        arstN       = 1'b0;
        inValid     = 1'b0;
        branchTaken = 1'b0;
        inInstr     = '0;
        inReg1Data  = '0;
        inImm       = '0;
        void'($urandom(14443));   // Fixed seed for the idle gaps
        loadVectors();
        numVecs = vecs.size();
        if (numVecs == 0) begin
            $display("The stimulus file holds no vectors");
            $display("Something failed");
            $fatal(1, "Empty stimulus");
        end else begin
            repeat (2) @(posedge clk);
            arstN <= 1'b1;
            for (int i = 0; i < numVecs; i++) begin
                v    = vecs[i];
                rnd  = $urandom;
                pick = (v.valid == 2'd2) ? rnd[0] : v.valid[0];
                @(posedge clk);
                inValid     <= pick;
                inInstr     <= v.instr;
                inReg1Data  <= v.reg1Data;
                inImm       <= v.imm;
                branchTaken <= v.branch;
                @(negedge clk);    // Outputs settled mid-cycle
                expOutValid = (v.expOut == 2'd2) ? (pick & v.expReady) : v.expOut[0];
                checkValue(int'(inReady), int'(v.expReady), $sformatf("vector %0d inReady", i));
                checkValue(int'(outValid), int'(expOutValid),
                           $sformatf("vector %0d outValid", i));
                checkValue(int'(outIssue.fwd), int'(v.expFwd), $sformatf("vector %0d fwd", i));
                checkValue(int'(outIssue.instr), int'(v.instr),
                           $sformatf("vector %0d instr", i));
            end
            $display("Everything OK");
            $finish;
        end
    end

    // Reset, all vectors and some slack
    initial begin
        wait (numVecs >= 0);
        #((numVecs + 20) * 8);
        $display("Timeout: the stimulus did not complete in time");
        $display("Something failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: hazard_properties.sv
`timescale 1ns/1ps
`include "hazard_defines.svh"

module hazardProperties (
    input logic                                    clk,
    input logic                                    arstN,
    input logic                                    inValid,
    input logic                                    inReady,
    input logic                                    outValid,
    input hazard_pkg::decodeT                      dec,
    input hazard_pkg::regTagT [`SHADOW_DEPTH-1:0]  regTags,
    input hazard_pkg::memTagT [`SHADOW_DEPTH-1:0]  memTags
);

    logic anyValid; // Some shadow stage holds a live tag

    always_comb begin
        anyValid = 1'b0;
        for (int s = 0; s < `SHADOW_DEPTH; s++) begin
            anyValid = anyValid | regTags[s].valid | memTags[s].valid;
        end
    end

    // Without a transfer only a bubble reaches ID
    bubbleOnStall: assert property (@(posedge clk) disable iff (!arstN)
        !outValid |=> (!regTags[0].valid && !memTags[0].valid))
        else $error("Shadow entry entered ID without a handshake transfer");

    // Exactly the cycle after a jump is held off
    bubbleAfterJump: assert property (@(posedge clk) disable iff (!arstN)
        (inValid && inReady && dec.isJump) |=> !inReady)
        else $error("No fetch bubble after a jump transfer");

    emptyAfterReset: assert property (@(posedge clk) $rose(arstN) |-> !anyValid)
        else $error("Shadow entry valid right after reset");

endmodule

bind hazardCtrl hazardProperties props (
    .clk(clk), .arstN(arstN), .inValid(inValid), .inReady(inReady),
    .outValid(outValid), .dec(dec),
    .regTags(regTags), .memTags(memTags)
);

// File: hazardUnit.sv
`timescale 1ns/1ps
`include "hazard_defines.svh"

module hazardUnit (
    input  logic                clk,
    input  logic                arstN,
    input  logic                inValid,
    input  logic                branchTaken, // Resolved outside this block
    input  hazard_pkg::instrT   inInstr,
    input  logic [`DATA_W-1:0]  inReg1Data,
    input  logic [`DATA_W-1:0]  inImm,
    output logic                inReady,
    output logic                outValid,
    output hazard_pkg::issueT   outIssue
);

    hazard_pkg::decodeT                      dec;
    hazard_pkg::fwdT                         fwd;
    hazard_pkg::regTagT                      regTagIn;
    hazard_pkg::memTagT                      memTagIn;
    hazard_pkg::regTagT [`SHADOW_DEPTH-1:0]  regTags;
    hazard_pkg::memTagT [`SHADOW_DEPTH-1:0]  memTags;

    instrDecode decoder (.instr(inInstr), .reg1Data(inReg1Data), .imm(inImm), .dec(dec));

    // Register writers in flight
    stageShadow #(.tagT(hazard_pkg::regTagT)) regShadow (
        .clk(clk), .arstN(arstN), .branchTaken(branchTaken),
        .tagIn(regTagIn), .tags(regTags)
    );

    // Memory addresses in flight
    stageShadow #(.tagT(hazard_pkg::memTagT)) memShadow (
        .clk(clk), .arstN(arstN), .branchTaken(branchTaken),
        .tagIn(memTagIn), .tags(memTags)
    );

    hazardCtrl ctrl (
        .clk(clk), .arstN(arstN), .inValid(inValid), .branchTaken(branchTaken),
        .dec(dec), .regTags(regTags), .memTags(memTags),
        .inReady(inReady), .outValid(outValid), .fwd(fwd),
        .regTagIn(regTagIn), .memTagIn(memTagIn)
    );

    assign outIssue = '{instr: inInstr, fwd: fwd}; // Selects travel with the word

endmodule

// File: hazardCtrl.sv
`timescale 1ns/1ps
`include "hazard_defines.svh"

module hazardCtrl (
    input  logic                                    clk,
    input  logic                                    arstN,
    input  logic                                    inValid,
    input  logic                                    branchTaken,
    input  hazard_pkg::decodeT                      dec,
    input  hazard_pkg::regTagT [`SHADOW_DEPTH-1:0]  regTags,
    input  hazard_pkg::memTagT [`SHADOW_DEPTH-1:0]  memTags,
    output logic                                    inReady,
    output logic                                    outValid,
    output hazard_pkg::fwdT                         fwd,
    output hazard_pkg::regTagT                      regTagIn,
    output hazard_pkg::memTagT                      memTagIn
);

    // Shadow slots
    localparam int StId  = 0;
    localparam int StEx  = 1;
    localparam int StMem = 2;
    localparam int StWb  = 3;

    logic       idLive;      // ID entry not squashed this cycle
    logic [3:0] rsHit;       // rs matches a writer, per stage
    logic [3:0] rtHit;       // Same for rt
    logic       regHazard;
    logic       memHazard;
    logic       transfer;
    logic       jumpBubble;  // Set the cycle after a jump issues

    assign idLive = ~branchTaken;

    // Source versus destination compare for every stage
    always_comb begin
        for (int s = 0; s < `SHADOW_DEPTH; s++) begin
            rsHit[s] = dec.usesRs & regTags[s].valid & (regTags[s].rd == dec.rs);
            rtHit[s] = dec.usesRt & regTags[s].valid & (regTags[s].rd == dec.rt);
        end
        rsHit[StId] = rsHit[StId] & idLive;
        rtHit[StId] = rtHit[StId] & idLive;
    end

    // Load-use from ID, and anything too old to forward from MEM or WB
    assign regHazard = ((rsHit[StId] | rtHit[StId]) & regTags[StId].isLoad)
                     | rsHit[StMem] | rtHit[StMem]
                     | rsHit[StWb]  | rtHit[StWb];

    // Same address as any memory op still in flight
    always_comb begin
        memHazard = 1'b0;
        for (int s = 0; s < `SHADOW_DEPTH; s++) begin
            if (memTags[s].valid && (memTags[s].addr == dec.memAddr) &&
                (s != StId || idLive)) begin
                memHazard = dec.isMem;
            end
        end
    end

    assign inReady  = ~regHazard & ~memHazard & ~jumpBubble; // Independent of inValid
    assign transfer = inValid & inReady;
    assign outValid = transfer;

    // Forwarding, the younger ID writer wins over EX
    always_comb begin
        fwd.exToExRs  = rsHit[StId] & ~regTags[StId].isLoad;
        fwd.exToExRt  = rtHit[StId] & ~regTags[StId].isLoad;
        fwd.memToExRs = rsHit[StEx] & ~rsHit[StId];
        fwd.memToExRt = rtHit[StEx] & ~rtHit[StId];
    end

    // New shadow entries, bubbles when nothing transfers
    always_comb begin
        regTagIn        = '0;
        memTagIn        = '0;
        if (transfer) begin
            regTagIn.valid  = dec.writesReg;
            regTagIn.rd     = dec.rd;
            regTagIn.isLoad = dec.isLoad;
            memTagIn.valid  = dec.isMem;
            memTagIn.addr   = dec.memAddr;
        end
    end

    // One fetch bubble behind every jump
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            jumpBubble <= 1'b0;
        end else begin
            jumpBubble <= transfer & dec.isJump;
        end
    end

endmodule

// File: stageShadow.sv
`timescale 1ns/1ps
`include "hazard_defines.svh"

// Mirrors one tag per stage so the check can see what is in flight
module stageShadow #(
    parameter type tagT = hazard_pkg::regTagT
) (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       branchTaken, // Kills the ID entry
    input  tagT                        tagIn,       // Bubble unless a transfer
    output tagT [`SHADOW_DEPTH-1:0]    tags         // [0] ID .. [3] WB
);

    localparam int TagW = $bits(tagT);

    tagT killed; // ID entry on its way to EX

    // The leading bit of every tag is its valid flag
    always_comb begin
        killed = tags[0];
        if (branchTaken) begin
            killed[TagW-1] = 1'b0; // Squashed, payload left as is
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            tags <= '0;                          // All stages empty
        end else begin
            tags[0] <= tagIn;                    // IF -> ID
            tags[1] <= killed;                   // ID -> EX
            for (int i = 2; i < `SHADOW_DEPTH; i++) begin
                tags[i] <= tags[i-1];            // EX -> MEM -> WB
            end
        end
    end

    // Downstream never stalls, so the chain shifts every cycle

endmodule

// File: instrDecode.sv
`timescale 1ns/1ps
`include "hazard_defines.svh"

module instrDecode (
    input  hazard_pkg::instrT   instr,
    input  logic [`DATA_W-1:0]  reg1Data, // Base register value
    input  logic [`DATA_W-1:0]  imm,
    output hazard_pkg::decodeT  dec
);

    logic isJ;
    logic isJal;
    logic isJalr;
    logic isLd;
    logic isSt;
    logic isNop;

    // Opcode classes
    assign isJ    = (instr.opcode == `OP_J);
    assign isJal  = (instr.opcode == `OP_JAL);
    assign isJalr = (instr.opcode == `OP_JALR);
    assign isLd   = (instr.opcode == `OP_LD);
    assign isSt   = (instr.opcode == `OP_ST);
    assign isNop  = (instr.opcode == `OP_NOP);

    always_comb begin
        dec.rs      = instr.rs;
        dec.rt      = instr.rt;
        dec.isLoad  = isLd;
        dec.isMem   = isLd | isSt;
        dec.isJump  = isJ | isJal | isJalr;
        dec.memAddr = reg1Data + imm; // Effective address, carry dropped

        // Which sources are actually read
        dec.usesRs  = ~(isNop | isJ | isJal);     // JALR reads its target from rs
        dec.usesRt  = ~(isNop | dec.isJump | isLd); // Store reads its data from rt

        // Destination register
        if (isJal | isJalr) begin
            dec.rd        = `LINK_REG;           // Linking jumps write r7
            dec.writesReg = 1'b1;
        end else if (isLd) begin
            dec.rd        = instr.rt;            // Load result lands in rt
            dec.writesReg = 1'b1;
        end else if (isSt | isJ | isNop) begin
            dec.rd        = '0;
            dec.writesReg = 1'b0;
        end else begin
            dec.rd        = instr.rest[4:2];     // ALU destination
            dec.writesReg = 1'b1;
        end
    end

endmodule

// File: hazard_pkg.sv
`include "hazard_defines.svh"

package hazard_pkg;

    // Raw instruction word as seen at fetch
    typedef struct packed {
        logic [4:0]         opcode; // Bits 15..11
        logic [`REG_AW-1:0] rs;     // Bits 10..8, base register for memory ops
        logic [`REG_AW-1:0] rt;     // Bits 7..5
        logic [4:0]         rest;   // ALU destination in the upper three bits
    } instrT;

    // Everything the hazard check needs to know about one instruction
    typedef struct packed {
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic               usesRs;    // rs is really read
        logic               usesRt;    // rt is really read
        logic [`REG_AW-1:0] rd;
        logic               writesReg;
        logic               isLoad;
        logic               isMem;     // Load or store
        logic               isJump;    // Needs one fetch bubble after it
        logic [`DATA_W-1:0] memAddr;   // Base plus immediate
    } decodeT;

    // Register writer tag, valid must stay the leading bit
    typedef struct packed {
        logic               valid;
        logic [`REG_AW-1:0] rd;
        logic               isLoad; // Data only ready after MEM
    } regTagT;

    // Memory access tag, valid leads here as well
    typedef struct packed {
        logic               valid;
        logic [`DATA_W-1:0] addr;
    } memTagT;

    // Forwarding selects that ride along with the instruction
    typedef struct packed {
        logic exToExRs;
        logic memToExRs;
        logic exToExRt;
        logic memToExRt;
    } fwdT;

    // What leaves toward ID
    typedef struct packed {
        instrT instr;
        fwdT   fwd;
    } issueT;

endpackage

// File: hazard_defines.svh
`ifndef HAZARD_DEFINES_SVH
`define HAZARD_DEFINES_SVH

// Datapath and address width
`define DATA_W 16
`define REG_AW 3        // Eight registers

// Opcodes live in instruction bits 15..11
`define OP_NOP  5'b00001
`define OP_J    5'b00100
`define OP_JAL  5'b00110 // Links into LINK_REG
`define OP_JALR 5'b00111 // Links, target from rs
`define OP_ST   5'b10000
`define OP_LD   5'b10001

`define LINK_REG 3'd7     // Return address register for JAL/JALR

`define SHADOW_DEPTH 4    // ID, EX, MEM, WB

`endif
